// ==== rtl/hps_io_cfg.svh ====
// host I/O bridge configuration: bus widths, counts and defaults
`ifndef HPS_IO_CFG_SVH
`define HPS_IO_CFG_SVH

////////////////////////////////////////
// host word bus
////////////////////////////////////////

// word width of io_din and io_dout
`define HPS_WORD_W 16

// number of digital joysticks
`define HPS_JOY_NUM 6

////////////////////////////////////////
// file download and keyboard line
////////////////////////////////////////

// download address width, byte addressed
`define HPS_ADDR_W 25

// PS/2 half period in system clocks
`define HPS_PS2_DIV_DEF 2000

// log2 of the keyboard FIFO depth
`define HPS_PS2_FIFO_BITS 5

`endif

// ==== rtl/hps_cmd_pkg.sv ====
// host command opcodes carried in the first word of each bus transaction
package hps_cmd_pkg;

	////////////////////////////////////////
	// command words
	////////////////////////////////////////

	typedef enum logic [15:0] {
		CMD_NONE        = 16'h0000,
		// settings and digital joysticks
		CMD_CFG         = 16'h0001,
		CMD_JOY0        = 16'h0002,
		CMD_JOY1        = 16'h0003,
		CMD_KBD         = 16'h0005,
		CMD_JOY2        = 16'h0010,
		CMD_JOY3        = 16'h0011,
		CMD_JOY4        = 16'h0012,
		CMD_JOY5        = 16'h0013,
		// status word and readbacks
		CMD_STATUS      = 16'h001E,
		CMD_STATUS_REQ  = 16'h0029,
		CMD_CAPS        = 16'h002B,
		CMD_MENUMASK    = 16'h002E,
		// file download
		CMD_FILE_TX     = 16'h0053,
		CMD_FILE_TX_DAT = 16'h0054,
		CMD_FILE_INDEX  = 16'h0055,
		CMD_FILE_INFO   = 16'h0056
	} hps_cmd_e;

endpackage

// ==== rtl/ps2_pkg.sv ====
// PS/2 transmit states and keyboard word tag shared by decoder and device
package ps2_pkg;

	// one state per bit on the line, start bit goes out on leaving idle
	typedef enum logic [3:0] {
		TX_IDLE,
		TX_DATA0, TX_DATA1, TX_DATA2, TX_DATA3,
		TX_DATA4, TX_DATA5, TX_DATA6, TX_DATA7,
		TX_PARITY,
		TX_STOP,
		TX_DONE
	} ps2_tx_state_e;

	// upper byte of a keyboard word that is meant for the device only
	localparam logic [7:0] PS2_SKIP_TAG = 8'hFF;

endpackage

// ==== rtl/hps_cmd_decoder.sv ====
// host command decoder: settings, joysticks, status, readbacks and key events
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module hps_cmd_decoder
	import hps_cmd_pkg::*;
	import ps2_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  logic [`HPS_WORD_W-1:0] io_din,
	input  logic [31:0]            status_in,
	input  logic                   status_set,
	input  logic [`HPS_WORD_W-1:0] status_menumask,
	output logic [`HPS_WORD_W-1:0] io_dout,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic [`HPS_WORD_W-1:0] joystick_0,
	output logic [`HPS_WORD_W-1:0] joystick_1,
	output logic [`HPS_WORD_W-1:0] joystick_2,
	output logic [`HPS_WORD_W-1:0] joystick_3,
	output logic [`HPS_WORD_W-1:0] joystick_4,
	output logic [`HPS_WORD_W-1:0] joystick_5,
	output logic [31:0]            status,
	output logic [10:0]            ps2_key,
	output logic [7:0]             kbd_data,
	output logic                   kbd_we
);

	hps_cmd_e               cmd;
	logic [3:0]             word_cnt;
	logic                   cmd_stb;
	logic                   data_stb;
	logic [31:0]            ps2_key_raw;
	logic                   ps2skip;
	logic                   pressed;
	logic                   extended;
	logic                   status_set_d;
	logic [3:0]             req_cnt;
	logic [31:0]            status_req;
	logic [`HPS_WORD_W-1:0] joy [`HPS_JOY_NUM];

	assign cmd_stb  = io_enable && io_strobe && (word_cnt == 4'd0);
	assign data_stb = io_enable && io_strobe && (word_cnt != 4'd0);

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];
	assign joystick_4 = joy[4];
	assign joystick_5 = joy[5];

	// a break code is F0 followed by the key, E0 may sit in front of either form
	assign pressed  = (ps2_key_raw[15:8] != 8'hF0);
	assign extended = pressed ? (ps2_key_raw[15:8] == 8'hE0) : (ps2_key_raw[23:16] == 8'hE0);

	////////////////////////////////////////
	// status change requests
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_set_d <= 1'b0;
			req_cnt      <= 4'd0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d)
				req_cnt <= req_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_d)
			status_req <= status_in;
	end

	////////////////////////////////////////
	// keyboard byte history
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (cmd_stb && io_din == CMD_KBD) begin
			ps2_key_raw <= '0;
		end else if (data_stb && cmd == CMD_KBD) begin
			kbd_data <= io_din[7:0];
			if (io_din[15:8] != PS2_SKIP_TAG && !ps2skip)
				ps2_key_raw <= {ps2_key_raw[23:0], io_din[7:0]};
		end
	end

	////////////////////////////////////////
	// command and data words
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd                <= CMD_NONE;
			word_cnt           <= 4'd0;
			ps2skip            <= 1'b0;
			io_dout            <= '0;
			buttons            <= 2'b00;
			forced_scandoubler <= 1'b0;
			status             <= '0;
			ps2_key            <= '0;
			kbd_we             <= 1'b0;
			for (int i = 0; i < `HPS_JOY_NUM; i++)
				joy[i] <= '0;
		end else begin
			kbd_we <= 1'b0;
			if (!io_enable) begin
				// publish the key event once the transaction has closed
				if (cmd == CMD_KBD)
					ps2_key <= {~ps2_key[10],
						ps2skip ? ps2_key[9:0] : {pressed, extended, ps2_key_raw[7:0]}};
				cmd      <= CMD_NONE;
				word_cnt <= 4'd0;
				ps2skip  <= 1'b0;
				io_dout  <= '0;
			end else if (io_strobe) begin
				io_dout <= '0;
				if (~&word_cnt)
					word_cnt <= word_cnt + 4'd1;
				if (word_cnt == 4'd0) begin
					cmd <= hps_cmd_e'(io_din);
					case (io_din)
						CMD_STATUS_REQ: io_dout <= {8'h00, 4'hA, req_cnt};
						CMD_CAPS:       io_dout <= 16'h0001;
						default:        io_dout <= '0;
					endcase
				end else begin
					case (cmd)
						CMD_CFG: begin
							buttons            <= io_din[1:0];
							forced_scandoubler <= io_din[4];
						end
						CMD_JOY0: joy[0] <= io_din;
						CMD_JOY1: joy[1] <= io_din;
						CMD_JOY2: joy[2] <= io_din;
						CMD_JOY3: joy[3] <= io_din;
						CMD_JOY4: joy[4] <= io_din;
						CMD_JOY5: joy[5] <= io_din;
						CMD_STATUS: begin
							if (word_cnt == 4'd1)
								status[15:0] <= io_din;
							else if (word_cnt == 4'd2)
								status[31:16] <= io_din;
						end
						CMD_KBD: begin
							// every byte goes to the device, tagged or not
							kbd_we <= 1'b1;
							if (io_din[15:8] == PS2_SKIP_TAG)
								ps2skip <= 1'b1;
						end
						CMD_STATUS_REQ: begin
							if (word_cnt == 4'd1)
								io_dout <= status_req[15:0];
							else if (word_cnt == 4'd2)
								io_dout <= status_req[31:16];
						end
						CMD_MENUMASK: begin
							if (word_cnt == 4'd1)
								io_dout <= status_menumask;
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// ==== rtl/hps_file_loader.sv ====
// file download tracker turning host data words into the ioctl write stream
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module hps_file_loader
	import hps_cmd_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  logic [`HPS_WORD_W-1:0] io_din,
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic                   ioctl_wr,
	output logic [`HPS_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]             ioctl_dout,
	output logic [31:0]            ioctl_file_ext
);

	hps_cmd_e               cmd;
	logic                   has_cmd;
	logic [1:0]             info_cnt;
	logic [`HPS_ADDR_W-1:0] addr;
	// write request, delayed one more cycle onto ioctl_wr
	logic                   wr;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd            <= CMD_NONE;
			has_cmd        <= 1'b0;
			info_cnt       <= 2'd0;
			addr           <= '0;
			wr             <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= 8'h00;
			ioctl_addr     <= '0;
			ioctl_dout     <= 8'h00;
			ioctl_file_ext <= '0;
		end else begin
			ioctl_wr <= wr;
			wr       <= 1'b0;
			if (!io_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd      <= hps_cmd_e'(io_din);
					has_cmd  <= 1'b1;
					info_cnt <= 2'd0;
				end else begin
					case (cmd)
						CMD_FILE_INFO: begin
							// extension arrives high half first, extra words ignored
							if (!info_cnt[1]) begin
								if (info_cnt == 2'd0)
									ioctl_file_ext[31:16] <= io_din;
								else
									ioctl_file_ext[15:0] <= io_din;
								info_cnt <= info_cnt + 2'd1;
							end
						end
						CMD_FILE_INDEX: ioctl_index <= io_din[7:0];
						CMD_FILE_TX: begin
							if (io_din[7:0] != 8'h00) begin
								addr           <= '0;
								ioctl_download <= 1'b1;
							end else begin
								// last address that carried a data byte
								ioctl_addr     <= addr - 1'b1;
								ioctl_download <= 1'b0;
							end
						end
						CMD_FILE_TX_DAT: begin
							ioctl_addr <= addr;
							ioctl_dout <= io_din[7:0];
							wr         <= 1'b1;
							addr       <= addr + 1'b1;
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// ==== rtl/ps2_device.sv ====
// PS/2 keyboard device: bit clock divider, transmit FIFO and frame serializer
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module ps2_device
	import ps2_pkg::*;
#(
	parameter int PS2DIV    = `HPS_PS2_DIV_DEF,
	parameter int FIFO_BITS = `HPS_PS2_FIFO_BITS
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [7:0] wdata,
	input  logic       we,
	input  logic       ps2_clk_in,
	input  logic       ps2_dat_in,
	output logic       ps2_clk_out,
	output logic       ps2_dat_out
);

	localparam int DIV_W = $clog2(PS2DIV + 2);

	logic [DIV_W-1:0]     div_cnt;
	logic                 div_hit;
	logic                 clk_ps2;
	logic                 clk_rise;
	logic                 clk_fall;
	logic [1:0]           clk_sync;
	logic [1:0]           dat_sync;
	logic                 line_idle;
	logic [7:0]           fifo_mem [1 << FIFO_BITS];
	logic [FIFO_BITS-1:0] wptr;
	logic [FIFO_BITS-1:0] rptr;
	ps2_tx_state_e        tx_state;
	logic [7:0]           tx_byte;
	logic                 parity;
	logic [1:0]           timeout;

	////////////////////////////////////////
	// bit clock
	////////////////////////////////////////

	assign div_hit  = (div_cnt == DIV_W'(PS2DIV));
	assign clk_rise = div_hit && !clk_ps2;
	assign clk_fall = div_hit && clk_ps2;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_cnt <= '0;
			clk_ps2 <= 1'b0;
		end else if (div_hit) begin
			div_cnt <= '0;
			clk_ps2 <= ~clk_ps2;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// line inputs and FIFO
	////////////////////////////////////////

	// both lines released by the host means the bus is free for a frame
	assign line_idle = clk_sync[1] && dat_sync[1];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk_in};
			dat_sync <= {dat_sync[0], ps2_dat_in};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (we)
			fifo_mem[wptr] <= wdata;
	end

	////////////////////////////////////////
	// serializer
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wptr        <= '0;
			rptr        <= '0;
			tx_state    <= TX_IDLE;
			parity      <= 1'b1;
			timeout     <= 2'd3;
			ps2_clk_out <= 1'b1;
			ps2_dat_out <= 1'b1;
		end else begin
			// a full FIFO simply wraps over the oldest bytes
			if (we)
				wptr <= wptr + 1'b1;

			if (clk_rise) begin
				ps2_clk_out <= 1'b1;
				case (tx_state)
					TX_IDLE: begin
						if (!line_idle) begin
							timeout <= 2'd3;
						end else if (wptr != rptr) begin
							timeout <= timeout - 2'd1;
							if (timeout == 2'd0) begin
								tx_byte     <= fifo_mem[rptr];
								rptr        <= rptr + 1'b1;
								parity      <= 1'b1;
								// start bit
								ps2_dat_out <= 1'b0;
								tx_state    <= TX_DATA0;
							end
						end
					end
					TX_DATA0, TX_DATA1, TX_DATA2, TX_DATA3,
					TX_DATA4, TX_DATA5, TX_DATA6, TX_DATA7: begin
						// lsb first, odd parity accumulates as bits go out
						ps2_dat_out <= tx_byte[0];
						tx_byte     <= {1'b0, tx_byte[7:1]};
						parity      <= parity ^ tx_byte[0];
						tx_state    <= ps2_tx_state_e'(tx_state + 4'd1);
					end
					TX_PARITY: begin
						ps2_dat_out <= parity;
						tx_state    <= TX_STOP;
					end
					TX_STOP: begin
						ps2_dat_out <= 1'b1;
						tx_state    <= TX_DONE;
					end
					default: begin
						timeout  <= 2'd3;
						tx_state <= TX_IDLE;
					end
				endcase
			end

			// clock pulses low only while a frame is on the line
			if (clk_fall)
				ps2_clk_out <= (tx_state == TX_IDLE);
		end
	end

endmodule

// ==== rtl/hps_io.sv ====
// host I/O bridge top: command decoder, file loader and PS/2 keyboard device
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module hps_io #(
	parameter int PS2DIV = `HPS_PS2_DIV_DEF
) (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	// host word bus
	input  logic                    io_enable,
	input  logic                    io_strobe,
	input  logic [`HPS_WORD_W-1:0]  io_din,
	output logic [`HPS_WORD_W-1:0]  io_dout,
	output logic                    io_wait,
	// settings
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output logic [`HPS_WORD_W-1:0]  joystick_0,
	output logic [`HPS_WORD_W-1:0]  joystick_1,
	output logic [`HPS_WORD_W-1:0]  joystick_2,
	output logic [`HPS_WORD_W-1:0]  joystick_3,
	output logic [`HPS_WORD_W-1:0]  joystick_4,
	output logic [`HPS_WORD_W-1:0]  joystick_5,
	output logic [31:0]             status,
	input  logic [31:0]             status_in,
	input  logic                    status_set,
	input  logic [`HPS_WORD_W-1:0]  status_menumask,
	output logic [10:0]             ps2_key,
	// file download
	output logic                    ioctl_download,
	output logic [7:0]              ioctl_index,
	output logic                    ioctl_wr,
	output logic [`HPS_ADDR_W-1:0]  ioctl_addr,
	output logic [7:0]              ioctl_dout,
	output logic [31:0]             ioctl_file_ext,
	input  logic                    ioctl_wait,
	// keyboard line
	output logic                    ps2_kbd_clk_out,
	output logic                    ps2_kbd_data_out,
	input  logic                    ps2_kbd_clk_in,
	input  logic                    ps2_kbd_data_in
);

	logic [7:0] kbd_data;
	logic       kbd_we;

	// the core stalls the host directly
	assign io_wait = ioctl_wait;

	hps_cmd_decoder u_cmd_decoder (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.joystick_4         (joystick_4),
		.joystick_5         (joystick_5),
		.status             (status),
		.ps2_key            (ps2_key),
		.kbd_data           (kbd_data),
		.kbd_we             (kbd_we)
	);

	hps_file_loader u_file_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.io_enable      (io_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

	ps2_device #(
		.PS2DIV    (PS2DIV),
		.FIFO_BITS (`HPS_PS2_FIFO_BITS)
	) u_keyboard (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.wdata       (kbd_data),
		.we          (kbd_we),
		.ps2_clk_in  (ps2_kbd_clk_in),
		.ps2_dat_in  (ps2_kbd_data_in),
		.ps2_clk_out (ps2_kbd_clk_out),
		.ps2_dat_out (ps2_kbd_data_out)
	);

endmodule

// ==== verification/hps_io_assertions.sv ====
// host I/O bridge port rules checked by concurrent assertions bound to the top level
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module hps_io_assertions (
	input logic                   clk_sys,
	input logic                   rst_n,
	input logic                   io_enable,
	input logic [`HPS_WORD_W-1:0] io_dout,
	input logic                   ioctl_wr,
	input logic [10:0]            ps2_key
);

	// read data drops once the host closes the transaction
	dout_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!io_enable |=> (io_dout == '0))
		else $error("io_dout not zero in the cycle after io_enable low");

	wr_after_reset: assert property (@(posedge clk_sys)
		$rose(rst_n) |-> !ioctl_wr)
		else $error("ioctl_wr high in the first cycle after reset release");

	// key events are published only when the transaction has ended
	key_update: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ps2_key != $past(ps2_key)) |-> $past(!io_enable))
		else $error("ps2_key changed while io_enable was high");

endmodule

bind hps_io hps_io_assertions u_assertions (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.io_enable (io_enable),
	.io_dout   (io_dout),
	.ioctl_wr  (ioctl_wr),
	.ps2_key   (ps2_key)
);

// ==== verification/hps_io_tb.sv ====
// host I/O bridge testbench: table-driven bus transactions with PS/2 and write monitors
`timescale 1ns/100ps
`include "hps_io_cfg.svh"

module hps_io_tb
	import hps_cmd_pkg::*;
();

	localparam int PS2DIV   = 3;
	localparam int N_ROWS   = 22;
	localparam int N_FRAMES = 10;
	localparam int N_REQ    = 3;
	localparam int WATCHDOG_CYCLES = N_ROWS * 40 + N_FRAMES * 11 * 2 * (PS2DIV + 1) * 8;

	// output selectors of the stimulus table
	localparam int SEL_NONE   = 0;
	localparam int SEL_CFG    = 1;
	localparam int SEL_JOY0   = 2;
	localparam int SEL_STATUS = 8;
	localparam int SEL_KEY    = 9;
	localparam int SEL_INDEX  = 10;
	localparam int SEL_EXT    = 11;
	localparam int SEL_DL     = 12;

	logic                   clk_sys;
	logic                   rst_n;
	logic                   io_enable;
	logic                   io_strobe;
	logic [`HPS_WORD_W-1:0] io_din;
	logic [`HPS_WORD_W-1:0] io_dout;
	logic                   io_wait;
	logic [1:0]             buttons;
	logic                   forced_scandoubler;
	logic [`HPS_WORD_W-1:0] joystick_0;
	logic [`HPS_WORD_W-1:0] joystick_1;
	logic [`HPS_WORD_W-1:0] joystick_2;
	logic [`HPS_WORD_W-1:0] joystick_3;
	logic [`HPS_WORD_W-1:0] joystick_4;
	logic [`HPS_WORD_W-1:0] joystick_5;
	logic [31:0]            status;
	logic [31:0]            status_in;
	logic                   status_set;
	logic [`HPS_WORD_W-1:0] status_menumask;
	logic [10:0]            ps2_key;
	logic                   ioctl_download;
	logic [7:0]             ioctl_index;
	logic                   ioctl_wr;
	logic [`HPS_ADDR_W-1:0] ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic [31:0]            ioctl_file_ext;
	logic                   ioctl_wait;
	logic                   ps2_kbd_clk_out;
	logic                   ps2_kbd_data_out;
	logic                   ps2_kbd_clk_in;
	logic                   ps2_kbd_data_in;

	// stimulus table
	logic [15:0] tbl_cmd  [N_ROWS];
	logic [15:0] tbl_data [N_ROWS][4];
	int          tbl_cnt  [N_ROWS];
	int          tbl_sel  [N_ROWS];
	logic [31:0] tbl_exp  [N_ROWS];
	// expected io_dout after the command and after each data word
	logic [15:0] tbl_rd   [N_ROWS][5];
	int          row_n = 0;

	logic [31:0]                 lfsr_state;
	logic                        key_toggle = 1'b0;
	logic [`HPS_ADDR_W-1:0]      dl_addr = '0;
	logic [`HPS_ADDR_W+7:0]      wr_exp [$];
	logic [7:0]                  ps2_exp [$];
	logic [10:0]                 frame_bits = '0;
	int                          bit_cnt = 0;
	int                          frames_seen = 0;
	int                          frames_expected = 0;

	hps_io #(
		.PS2DIV (PS2DIV)
	) u_hps_io (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.joystick_4         (joystick_4),
		.joystick_5         (joystick_5),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wait         (ioctl_wait),
		.ps2_kbd_clk_out    (ps2_kbd_clk_out),
		.ps2_kbd_data_out   (ps2_kbd_data_out),
		.ps2_kbd_clk_in     (ps2_kbd_clk_in),
		.ps2_kbd_data_in    (ps2_kbd_data_in)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic stop_on_error();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	// galois form, taps for a maximal length 32-bit sequence
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic add_row(input logic [15:0] cmd, input logic [15:0] d0, input logic [15:0] d1,
		input logic [15:0] d2, input logic [15:0] d3, input int cnt, input int sel,
		input logic [31:0] exp);
		tbl_cmd[row_n]     = cmd;
		tbl_data[row_n][0] = d0;
		tbl_data[row_n][1] = d1;
		tbl_data[row_n][2] = d2;
		tbl_data[row_n][3] = d3;
		tbl_cnt[row_n]     = cnt;
		tbl_sel[row_n]     = sel;
		tbl_exp[row_n]     = exp;
		for (int k = 0; k < 5; k++)
			tbl_rd[row_n][k] = '0;
		row_n++;
	endtask

	////////////////////////////////////////
	// table of transactions
	////////////////////////////////////////

	task automatic build_table();
		logic [15:0] w0;
		logic [15:0] w1;
		logic [7:0]  c;
		logic [9:0]  key;
		w0 = {8'h00, 8'(rand_bits(8))};
		add_row(CMD_CFG, w0, 0, 0, 0, 1, SEL_CFG, {29'd0, w0[4], w0[1:0]});
		for (int j = 0; j < `HPS_JOY_NUM; j++) begin
			w0 = rand_bits(16);
			add_row((j < 2) ? CMD_JOY0 + j : CMD_JOY2 + (j - 2), w0, 0, 0, 0, 1,
				SEL_JOY0 + j, w0);
		end
		w0 = rand_bits(16);
		w1 = rand_bits(16);
		add_row(CMD_STATUS, w0, w1, 0, 0, 2, SEL_STATUS, {w1, w0});
		add_row(CMD_STATUS_REQ, 0, 0, 0, 0, 2, SEL_NONE, 0);
		tbl_rd[row_n-1][0] = {8'h00, 4'hA, 4'(N_REQ)};
		tbl_rd[row_n-1][1] = status_in[15:0];
		tbl_rd[row_n-1][2] = status_in[31:16];
		add_row(CMD_CAPS, 0, 0, 0, 0, 0, SEL_NONE, 0);
		tbl_rd[row_n-1][0] = 16'h0001;
		add_row(CMD_MENUMASK, 0, 0, 0, 0, 1, SEL_NONE, 0);
		tbl_rd[row_n-1][1] = status_menumask;

		// key events as {pressed, extended, code}
		c = rand_bits(8);
		add_row(CMD_KBD, {8'h00, c}, 0, 0, 0, 1, SEL_KEY, {22'd0, 2'b10, c});
		c = rand_bits(8);
		add_row(CMD_KBD, 16'h00F0, {8'h00, c}, 0, 0, 2, SEL_KEY, {22'd0, 2'b00, c});
		c = rand_bits(8);
		add_row(CMD_KBD, 16'h00E0, {8'h00, c}, 0, 0, 2, SEL_KEY, {22'd0, 2'b11, c});
		c = rand_bits(8);
		key = {2'b01, c};
		add_row(CMD_KBD, 16'h00E0, 16'h00F0, {8'h00, c}, 0, 3, SEL_KEY, {22'd0, key});
		// a tagged word hides the whole transaction from ps2_key
		w0 = {8'hFF, 8'(rand_bits(8))};
		c = rand_bits(8);
		add_row(CMD_KBD, w0, {8'h00, c}, 0, 0, 2, SEL_KEY, {22'd0, key});

		c = rand_bits(8);
		add_row(CMD_FILE_INDEX, {8'h00, c}, 0, 0, 0, 1, SEL_INDEX, {24'd0, c});
		w0 = rand_bits(16);
		w1 = rand_bits(16);
		add_row(CMD_FILE_INFO, w0, w1, 0, 0, 2, SEL_EXT, {w0, w1});
		add_row(CMD_FILE_TX, 16'h0001, 0, 0, 0, 1, SEL_DL, 1);
		for (int j = 0; j < 2; j++)
			add_row(CMD_FILE_TX_DAT, rand_bits(8), rand_bits(8), rand_bits(8), rand_bits(8),
				4, SEL_NONE, 0);
		add_row(CMD_FILE_TX, 16'h0000, 0, 0, 0, 1, SEL_DL, 0);
	endtask

	////////////////////////////////////////
	// bus and checks
	////////////////////////////////////////

	// one strobed word, then an idle cycle where io_dout is read back
	task automatic bus_word(input logic [15:0] w, output logic [15:0] rd);
		@(posedge clk_sys);
		#2;
		io_strobe = 1'b1;
		io_din    = w;
		@(posedge clk_sys);
		#2;
		io_strobe = 1'b0;
		rd        = io_dout;
	endtask

	task automatic check_output(input int r);
		case (tbl_sel[r])
			SEL_CFG:      check("buttons/forced_scandoubler",
				{29'd0, forced_scandoubler, buttons}, tbl_exp[r]);
			SEL_JOY0:     check("joystick_0", joystick_0, tbl_exp[r]);
			SEL_JOY0 + 1: check("joystick_1", joystick_1, tbl_exp[r]);
			SEL_JOY0 + 2: check("joystick_2", joystick_2, tbl_exp[r]);
			SEL_JOY0 + 3: check("joystick_3", joystick_3, tbl_exp[r]);
			SEL_JOY0 + 4: check("joystick_4", joystick_4, tbl_exp[r]);
			SEL_JOY0 + 5: check("joystick_5", joystick_5, tbl_exp[r]);
			SEL_STATUS:   check("status", status, tbl_exp[r]);
			SEL_KEY: begin
				key_toggle = ~key_toggle;
				check("ps2_key", ps2_key, {key_toggle, tbl_exp[r][9:0]});
			end
			SEL_INDEX:    check("ioctl_index", ioctl_index, tbl_exp[r]);
			SEL_EXT:      check("ioctl_file_ext", ioctl_file_ext, tbl_exp[r]);
			SEL_DL: begin
				check("ioctl_download", ioctl_download, tbl_exp[r]);
				// end of transfer publishes the last written address
				if (tbl_exp[r] == 0)
					check("ioctl_addr", ioctl_addr, dl_addr - 1'b1);
			end
			default: ;
		endcase
	endtask

	task automatic run_row(input int r);
		logic [15:0] rd;
		logic [15:0] w;
		@(posedge clk_sys);
		#2;
		io_enable = 1'b1;
		bus_word(tbl_cmd[r], rd);
		check("io_dout", rd, tbl_rd[r][0]);
		for (int k = 0; k < tbl_cnt[r]; k++) begin
			w = tbl_data[r][k];
			if (tbl_cmd[r] == CMD_KBD) begin
				ps2_exp.push_back(w[7:0]);
				frames_expected++;
			end
			if (tbl_cmd[r] == CMD_FILE_TX && w[7:0] != 8'h00)
				dl_addr = '0;
			if (tbl_cmd[r] == CMD_FILE_TX_DAT) begin
				wr_exp.push_back({dl_addr, w[7:0]});
				dl_addr = dl_addr + 1'b1;
			end
			bus_word(w, rd);
			check("io_dout", rd, tbl_rd[r][k+1]);
		end
		@(posedge clk_sys);
		#2;
		io_enable = 1'b0;
		repeat (2) @(posedge clk_sys);
		#2;
		check_output(r);
	endtask

	task automatic check_reset_values();
		check("io_dout", io_dout, 0);
		check("buttons/forced_scandoubler", {forced_scandoubler, buttons}, 0);
		check("joystick_0", joystick_0, 0);
		check("joystick_1", joystick_1, 0);
		check("joystick_2", joystick_2, 0);
		check("joystick_3", joystick_3, 0);
		check("joystick_4", joystick_4, 0);
		check("joystick_5", joystick_5, 0);
		check("status", status, 0);
		check("ps2_key", ps2_key, 0);
		check("ioctl_wr", ioctl_wr, 0);
		check("ioctl_download", ioctl_download, 0);
		check("ps2_kbd_clk_out", ps2_kbd_clk_out, 1);
		check("ps2_kbd_data_out", ps2_kbd_data_out, 1);
	endtask

	task automatic check_ps2_frame();
		logic [7:0] b;
		if (ps2_exp.size() == 0) begin
			$display("a PS/2 frame appeared with no keyboard byte written for it");
			stop_on_error();
		end
		b = ps2_exp.pop_front();
		check("ps2 start bit", frame_bits[0], 0);
		check("ps2 data", frame_bits[8:1], b);
		check("ps2 parity", frame_bits[9], ~^b);
		check("ps2 stop bit", frame_bits[10], 1);
		frames_seen++;
	endtask

	task automatic check_write();
		logic [`HPS_ADDR_W+7:0] e;
		if (wr_exp.size() == 0) begin
			$display("ioctl_wr pulsed with no data word sent");
			stop_on_error();
		end
		e = wr_exp.pop_front();
		check("ioctl_addr", ioctl_addr, e[`HPS_ADDR_W+7:8]);
		check("ioctl_dout", ioctl_dout, e[7:0]);
		check("ioctl_download", ioctl_download, 1);
	endtask

	////////////////////////////////////////
	// monitors and watchdog
	////////////////////////////////////////

	// frame bits shift in from the top, lsb first
	always @(negedge ps2_kbd_clk_out) begin
		if (rst_n) begin
			frame_bits = {ps2_kbd_data_out, frame_bits[10:1]};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 11) begin
				check_ps2_frame();
				bit_cnt = 0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (rst_n && ioctl_wr)
			check_write();
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("the run timed out before all transactions and PS/2 frames completed");
		stop_on_error();
	end

	initial begin
		rst_n           = 1'b0;
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		ioctl_wait      = 1'b0;
		ps2_kbd_clk_in  = 1'b1;
		ps2_kbd_data_in = 1'b1;
		lfsr_state      = 32'h8aff;
		repeat (4) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;
		@(posedge clk_sys);
		#2;
		check_reset_values();

		status_in       = rand_bits(32);
		status_menumask = rand_bits(16);
		build_table();
		repeat (N_REQ) begin
			@(posedge clk_sys);
			#2;
			status_set = 1'b1;
			@(posedge clk_sys);
			#2;
			status_set = 1'b0;
		end

		// io_wait follows ioctl_wait combinationally
		ioctl_wait = 1'b1;
		#1;
		check("io_wait", io_wait, 1);
		ioctl_wait = 1'b0;
		#1;
		check("io_wait", io_wait, 0);
		check_reset_values();

		for (int r = 0; r < row_n; r++)
			run_row(r);

		wait (frames_seen == frames_expected);
		@(posedge clk_sys);
		#2;
		check("pending ioctl writes", wr_exp.size(), 0);
		check("ps2_kbd_data_out", ps2_kbd_data_out, 1);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== hps_io.f ====
+incdir+rtl
rtl/hps_cmd_pkg.sv
rtl/ps2_pkg.sv
rtl/hps_cmd_decoder.sv
rtl/hps_file_loader.sv
rtl/ps2_device.sv
rtl/hps_io.sv
verification/hps_io_assertions.sv
verification/hps_io_tb.sv
